/* Bender.yml */
package:
  name: ay3891x

export_include_dirs:
  - common

sources:
  - common/ay_reg_pkg.sv
  - common/ay_sound_pkg.sv
  - design/ay_prescaler.sv
  - design/ay_regs.sv
  - tone/ay_tone_noise.sv
  - envelope/ay_env.sv
  - design/ay_mixer_dac.sv
  - design/ay3891x.sv
  - target: simulation
    files:
      - verif/ay_tb.sv

/* ay3891x.f */
+incdir+common
common/ay_reg_pkg.sv
common/ay_sound_pkg.sv
design/ay_prescaler.sv
design/ay_regs.sv
tone/ay_tone_noise.sv
envelope/ay_env.sv
design/ay_mixer_dac.sv
design/ay3891x.sv
verif/ay_tb.sv

/* common/ay_macros.svh */
/*
 * chip-level constants for the ay-3-891x style sound generator
 * include wherever the tick ratios or the register count are needed
 */
`ifndef AY_MACROS_SVH
`define AY_MACROS_SVH

// nominal chip clock in hz
`define AY_CLK_FREQ 1789773
// tone and noise step ratio
`define AY_TONE_DIV 16
// envelope step ratio
`define AY_ENV_DIV 256
// full register address space
`define AY_NUM_REGS 16

`endif

/* common/ay_reg_pkg.sv */
/*
 * register-side types of the sound generator
 * address names, mixer and amplitude fields, and the decoded register image
 * that the register file hands to the tone, envelope and mixer blocks
 */
`default_nettype none

package ay_reg_pkg;

    typedef enum logic [3:0] {
        REG_A_FINE,     REG_A_COARSE,
        REG_B_FINE,     REG_B_COARSE,
        REG_C_FINE,     REG_C_COARSE,
        REG_NOISE,      REG_MIXER,
        REG_A_AMP,      REG_B_AMP,      REG_C_AMP,
        REG_ENV_FINE,   REG_ENV_COARSE, REG_ENV_SHAPE,
        REG_IO_A,       REG_IO_B        // not implemented
    } ay_addr_e;

    // set bit turns the source off, as on the chip
    typedef struct packed {
        logic [1:0] io;                 // port direction, kept for readback
        logic [2:0] noise_off;          // c b a
        logic [2:0] tone_off;           // c b a
    } ay_mixer_t;

    typedef struct packed {
        logic       use_env;            // take level from envelope
        logic [3:0] level;              // fixed level
    } ay_amp_t;

    typedef struct packed {
        logic [2:0][11:0] tone_period;  // index 0 is channel a
        logic [4:0]       noise_period;
        ay_mixer_t        mixer;
        ay_amp_t [2:0]    amp;
        logic [15:0]      env_period;
        logic [3:0]       env_shape;
    } ay_regs_t;

endpackage

`default_nettype wire

/* common/ay_sound_pkg.sv */
/*
 * sound-side types of the sound generator
 * envelope sequencer state, envelope shape bits and the raw source bits
 * passed from the tone/noise block to the mixer
 */
`default_nettype none

package ay_sound_pkg;

    typedef enum logic {
        ENV_RUN,                        // ramping
        ENV_HOLD                        // level frozen
    } env_state_e;

    // same bit order as register 13
    typedef struct packed {
        logic cont;                     // continue
        logic attack;                   // ramp up first
        logic alternate;                // flip direction each ramp
        logic hold;                     // stop after first ramp
    } ay_shape_t;

    typedef struct packed {
        logic       noise;              // shared lfsr bit
        logic [2:0] tone;               // c b a square waves
    } ay_src_t;

endpackage

`default_nettype wire

/* design/ay3891x.sv */
/*
 * ay-3-891x style sound generator, top level
 * host writes and reads registers over the a0/wr_tick/rd_tick strobes
 * aout carries one pulse-density bit per channel
 */
`timescale 1ns/1ns
`default_nettype none
`include "ay_macros.svh"

module ay3891x #(
    parameter int CLK_FREQ = `AY_CLK_FREQ       // system clock, hz
) (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        a0,
    input  wire        wr_tick,
    input  wire  [7:0] wdata,
    input  wire        rd_tick,
    output wire  [7:0] rdata,
    output wire  [2:0] aout
);

    import ay_reg_pkg::*;
    import ay_sound_pkg::*;

    logic       tick16;             // tone/noise step
    logic       tick256;            // envelope step
    logic       shape_tick;
    ay_regs_t   regs;
    ay_src_t    src;
    logic [3:0] env_level;

    ay_prescaler #(
        .IN_FREQ (CLK_FREQ),
        .OUT_FREQ(`AY_CLK_FREQ / `AY_TONE_DIV)
    ) u_pre16 (
        .clk  (clk),
        .rst_n(rst_n),
        .tick (tick16)
    );

    ay_prescaler #(
        .IN_FREQ (CLK_FREQ),
        .OUT_FREQ(`AY_CLK_FREQ / `AY_ENV_DIV)
    ) u_pre256 (
        .clk  (clk),
        .rst_n(rst_n),
        .tick (tick256)
    );

    ay_regs u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .a0        (a0),
        .wr_tick   (wr_tick),
        .wdata     (wdata),
        .rd_tick   (rd_tick),
        .rdata     (rdata),
        .shape_tick(shape_tick),
        .regs      (regs)
    );

    ay_tone_noise u_tone_noise (
        .clk   (clk),
        .rst_n (rst_n),
        .tick16(tick16),
        .regs  (regs),
        .src   (src)
    );

    ay_env u_env (
        .clk       (clk),
        .rst_n     (rst_n),
        .tick256   (tick256),
        .shape_tick(shape_tick),
        .regs      (regs),
        .env_level (env_level)
    );

    ay_mixer_dac u_mixer_dac (
        .clk      (clk),
        .rst_n    (rst_n),
        .src      (src),
        .env_level(env_level),
        .regs     (regs),
        .aout     (aout)
    );

endmodule

`default_nettype wire

/* design/ay_mixer_dac.sv */
/*
 * mixer and pulse-density output
 * per channel, gates tone with noise, picks fixed or envelope amplitude
 * and emits amplitude high cycles out of every 16 while the gate is high
 */
`timescale 1ns/1ns
`default_nettype none

module ay_mixer_dac (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire ay_sound_pkg::ay_src_t src,
    input  wire  [3:0]            env_level,
    input  wire ay_reg_pkg::ay_regs_t regs,
    output logic [2:0]            aout          // c b a
);

    logic [2:0]      gate;
    logic [2:0][3:0] amp;
    logic [2:0][3:0] phase;         // pdm position within 16

    // a disabled source counts as high
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            gate[i] = (src.tone[i] | regs.mixer.tone_off[i]) &
                      (src.noise | regs.mixer.noise_off[i]);
            amp[i]  = regs.amp[i].use_env ? env_level : regs.amp[i].level;
        end
    end

    // ******************************
    // pulse-density output
    // ******************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= '0;
            aout  <= '0;
        end else begin
            for (int i = 0; i < 3; i++) begin
                // held at 0 while gated off, no phase crawl
                phase[i] <= gate[i] ? phase[i] + 4'h1 : 4'h0;
                aout[i]  <= gate[i] && (phase[i] < amp[i]);
            end
        end
    end

endmodule

`default_nettype wire

/* design/ay_prescaler.sv */
/*
 * tick prescaler
 * divides the system clock down to one-cycle tick pulses at OUT_FREQ
 */
`timescale 1ns/1ns
`default_nettype none

module ay_prescaler #(
    parameter int IN_FREQ  = 1789773,
    parameter int OUT_FREQ = 111860
) (
    input  wire  clk,
    input  wire  rst_n,
    output logic tick                   // one clock wide
);

    localparam int DIV = (IN_FREQ / OUT_FREQ < 1) ? 1 : IN_FREQ / OUT_FREQ;
    localparam int CW  = (DIV > 1) ? $clog2(DIV) : 1;

    logic [CW-1:0] cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else if (cnt == CW'(DIV - 1)) begin
            cnt  <= '0;                 // wrap
            tick <= 1'b1;
        end else begin
            cnt  <= cnt + 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* design/ay_regs.sv */
/*
 * host register file
 * a0=0 write latches the address, a0=1 write stores masked data
 * rd_tick loads rdata from the latched register
 * shape_tick follows a write to the envelope shape register
 */
`timescale 1ns/1ns
`default_nettype none
`include "ay_macros.svh"

module ay_regs (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  a0,            // 0 address, 1 data
    input  wire                  wr_tick,
    input  wire  [7:0]           wdata,
    input  wire                  rd_tick,
    output logic [7:0]           rdata,         // valid until next rd_tick
    output logic                 shape_tick,
    output ay_reg_pkg::ay_regs_t regs
);

    import ay_reg_pkg::*;

    ay_addr_e                     addr;         // latched address
    logic [`AY_NUM_REGS-1:0][7:0] view;         // readback image

    // readback, unimplemented bits as zero
    always_comb begin
        view = '0;
        for (int i = 0; i < 3; i++) begin
            view[2*i]   = regs.tone_period[i][7:0];
            view[2*i+1] = {4'h0, regs.tone_period[i][11:8]};
            view[8+i]   = {3'h0, regs.amp[i]};
        end
        view[REG_NOISE]      = {3'h0, regs.noise_period};
        view[REG_MIXER]      = regs.mixer;
        view[REG_ENV_FINE]   = regs.env_period[7:0];
        view[REG_ENV_COARSE] = regs.env_period[15:8];
        view[REG_ENV_SHAPE]  = {4'h0, regs.env_shape};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr       <= REG_A_FINE;
            regs       <= '0;
            rdata      <= 8'h00;
            shape_tick <= 1'b0;
        end else begin
            shape_tick <= wr_tick && a0 && (addr == REG_ENV_SHAPE);
            if (rd_tick)
                rdata <= view[addr];
            if (wr_tick && !a0)
                addr <= ay_addr_e'(wdata[3:0]);
            if (wr_tick && a0) begin
                case (addr)
                    REG_A_FINE:     regs.tone_period[0][7:0]  <= wdata;
                    REG_A_COARSE:   regs.tone_period[0][11:8] <= wdata[3:0];
                    REG_B_FINE:     regs.tone_period[1][7:0]  <= wdata;
                    REG_B_COARSE:   regs.tone_period[1][11:8] <= wdata[3:0];
                    REG_C_FINE:     regs.tone_period[2][7:0]  <= wdata;
                    REG_C_COARSE:   regs.tone_period[2][11:8] <= wdata[3:0];
                    REG_NOISE:      regs.noise_period         <= wdata[4:0];
                    REG_MIXER:      regs.mixer                <= ay_mixer_t'(wdata);
                    REG_A_AMP:      regs.amp[0]               <= ay_amp_t'(wdata[4:0]);
                    REG_B_AMP:      regs.amp[1]               <= ay_amp_t'(wdata[4:0]);
                    REG_C_AMP:      regs.amp[2]               <= ay_amp_t'(wdata[4:0]);
                    REG_ENV_FINE:   regs.env_period[7:0]      <= wdata;
                    REG_ENV_COARSE: regs.env_period[15:8]     <= wdata;
                    REG_ENV_SHAPE:  regs.env_shape            <= wdata[3:0];
                    default: ;                              // io ports a/b dropped
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* envelope/ay_env.sv */
/*
 * envelope generator
 * steps a 4-bit level once every env_period /256 ticks and follows the
 * sixteen shapes given by continue, attack, alternate and hold
 * a shape write restarts the envelope
 */
`timescale 1ns/1ns
`default_nettype none

module ay_env (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   tick256,
    input  wire                   shape_tick,     // restart
    input  wire ay_reg_pkg::ay_regs_t regs,
    output logic [3:0]            env_level
);

    import ay_sound_pkg::*;

    env_state_e  state;
    ay_shape_t   shape;
    logic        up;                // ramp direction
    logic [15:0] cnt;
    logic [15:0] len;               // period, 0 read as 1
    logic        step;
    logic        ramp_end;

    assign shape    = ay_shape_t'(regs.env_shape);
    assign len      = (regs.env_period == 16'd0) ? 16'd1 : regs.env_period;
    assign step     = tick256 && (cnt <= 16'd1);
    assign ramp_end = up ? (env_level == 4'hF) : (env_level == 4'h0);

    // period counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            cnt <= '0;
        else if (shape_tick)
            cnt <= len;                             // full period before first step
        else if (tick256)
            cnt <= (cnt <= 16'd1) ? len : cnt - 16'd1;
    end

    // ******************************
    // level sequencer
    // ******************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ENV_HOLD;
            up        <= 1'b0;
            env_level <= 4'h0;
        end else if (shape_tick) begin
            state     <= ENV_RUN;
            up        <= shape.attack;
            env_level <= shape.attack ? 4'h0 : 4'hF;
        end else if (step && state == ENV_RUN) begin
            if (!ramp_end) begin
                env_level <= up ? env_level + 4'h1 : env_level - 4'h1;
            end else if (!shape.cont) begin         // one-shot, drop and stay
                env_level <= 4'h0;
                state     <= ENV_HOLD;
            end else if (shape.hold) begin
                env_level <= shape.alternate ? ~env_level : env_level;
                state     <= ENV_HOLD;
            end else if (shape.alternate) begin
                up <= ~up;                          // triangle
            end else begin
                env_level <= up ? 4'h0 : 4'hF;      // sawtooth wrap
            end
        end
    end

endmodule

`default_nettype wire

/* tone/ay_tone_noise.sv */
/*
 * tone and noise sources
 * three square-wave dividers and one 17-bit noise lfsr, all stepped by
 * the /16 tick; outputs the raw source bits for the mixer
 */
`timescale 1ns/1ns
`default_nettype none

module ay_tone_noise (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   tick16,
    input  wire ay_reg_pkg::ay_regs_t regs,
    output ay_sound_pkg::ay_src_t src
);

    logic [2:0][11:0] tone_cnt;         // down counters
    logic [2:0][11:0] tone_len;         // period, 0 read as 1
    logic [2:0]       tone_q;
    logic [5:0]       noise_cnt;
    logic [5:0]       noise_len;        // twice the noise period
    logic [16:0]      lfsr;

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            tone_len[i] = (regs.tone_period[i] == 12'd0) ? 12'd1 : regs.tone_period[i];
        end
        noise_len = (regs.noise_period == 5'd0) ? 6'd2 : {regs.noise_period, 1'b0};
    end

    // ******************************
    // tone dividers
    // ******************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tone_cnt <= '0;
            tone_q   <= '0;
        end else if (tick16) begin
            for (int i = 0; i < 3; i++) begin
                if (tone_cnt[i] <= 12'd1) begin
                    tone_cnt[i] <= tone_len[i];     // reload
                    tone_q[i]   <= ~tone_q[i];      // half period done
                end else begin
                    tone_cnt[i] <= tone_cnt[i] - 12'd1;
                end
            end
        end
    end

    // ******************************
    // noise generator
    // ******************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            noise_cnt <= '0;
            lfsr      <= 17'h00001;               // must not start at zero
        end else if (tick16) begin
            if (noise_cnt <= 6'd1) begin
                noise_cnt <= noise_len;
                lfsr      <= {lfsr[0] ^ lfsr[3], lfsr[16:1]};   // shift right
            end else begin
                noise_cnt <= noise_cnt - 6'd1;
            end
        end
    end

    assign src = {lfsr[0], tone_q};             // noise, tone c b a

endmodule

`default_nettype wire

/* verif/ay_tb.sv */
/*
 * testbench for the ay-3-891x style sound generator
 * walks register readback, silence, fixed amplitude, tone rate,
 * envelope one-shot and sawtooth, and noise gating on the pdm outputs
 * compile from the project root with ay3891x.f, top module ay_tb
 */
`timescale 1ns/1ns
`default_nettype none
`include "ay_macros.svh"

module ay_tb;

    logic       clk;
    logic       rst_n;
    logic       a0;
    logic       wr_tick;
    logic [7:0] wdata;
    logic       rd_tick;
    wire  [7:0] rdata;
    wire  [2:0] aout;           // c b a

    int   mismatches;
    int   failures;             // timeouts and missing events
    logic quiet_check;          // aout must stay 0 while set

    ay3891x #(.CLK_FREQ(`AY_CLK_FREQ)) uut (
        .clk    (clk),
        .rst_n  (rst_n),
        .a0     (a0),
        .wr_tick(wr_tick),
        .wdata  (wdata),
        .rd_tick(rd_tick),
        .rdata  (rdata),
        .aout   (aout)
    );

    always #5 clk = ~clk;       // 10 ns period

    // implemented bits per register address
    function automatic logic [7:0] reg_mask(input int addr);
        case (addr)
            0, 2, 4, 7, 11, 12: reg_mask = 8'hFF;   // fine tune, mixer, env period
            1, 3, 5, 13:        reg_mask = 8'h0F;   // coarse tune, shape
            6, 8, 9, 10:        reg_mask = 8'h1F;   // noise, amplitudes
            default:            reg_mask = 8'h00;   // io ports, not stored
        endcase
    endfunction

    // ******************************
    // bus phases
    // ******************************
    task automatic write_reg(input logic [3:0] addr, input logic [7:0] data);
        @(posedge clk);
        a0      <= 1'b0;        // address phase
        wr_tick <= 1'b1;
        wdata   <= {4'h0, addr};
        @(posedge clk);
        a0      <= 1'b1;        // data phase
        wdata   <= data;
        @(posedge clk);
        wr_tick <= 1'b0;
        a0      <= 1'b0;
    endtask

    task automatic read_reg(input logic [3:0] addr, output logic [7:0] data);
        @(posedge clk);
        a0      <= 1'b0;
        wr_tick <= 1'b1;
        wdata   <= {4'h0, addr};
        @(posedge clk);
        wr_tick <= 1'b0;
        rd_tick <= 1'b1;
        @(posedge clk);
        rd_tick <= 1'b0;
        @(negedge clk);         // rdata loaded on the rd_tick edge
        data = rdata;
    endtask

    // silence monitor
    always @(negedge clk) begin
        if (quiet_check)
            assert (aout == 3'b000) else begin
                mismatches++;
                $display("MISMATCH at %0t: aout=%b, expected silence", $time, aout);
            end
    end

    task automatic quiet_for(input int cycles);
        @(posedge clk);
        quiet_check <= 1'b1;
        repeat (cycles) @(negedge clk);
        quiet_check <= 1'b0;
    endtask

    task automatic wait_for_high(input int limit, input string what);
        int  n;
        logic found;
        n     = 0;
        found = 1'b0;
        while (!found && n < limit) begin
            @(negedge clk);
            n++;
            found = (aout != 3'b000);
        end
        assert (found) else begin
            failures++;
            $display("timeout: no high on aout within %0d cycles (%s)", limit, what);
        end
    endtask

    // zero runs on channel a, first two runs skipped while the old count drains
    task automatic measure_tone(input int period);
        int run;
        int runs;
        int long_runs;
        int cycles;
        int nominal;
        run       = 0;
        runs      = 0;
        long_runs = 0;
        cycles    = 0;
        nominal   = `AY_TONE_DIV * period;
        while (long_runs < 4 && cycles < 200000) begin
            @(negedge clk);
            cycles++;
            if (!aout[0]) begin
                run++;
            end else if (run > 0) begin
                runs++;
                if (runs > 2 && run > 1) begin      // gate-low run
                    long_runs++;
                    assert (run >= nominal - 16 && run <= nominal + 16) else begin
                        mismatches++;
                        $display("MISMATCH at %0t: zero run %0d, expected %0d +/- 16",
                                 $time, run, nominal);
                    end
                end
                run = 0;
            end
        end
        assert (long_runs == 4) else begin
            failures++;
            $display("timeout: tone on channel a never settled into gate-low runs");
        end
    endtask

    task automatic check_noise();
        int   run;
        int   cycles;
        logic saw_long;
        logic saw_high;
        run      = 0;
        cycles   = 0;
        saw_long = 1'b0;
        saw_high = 1'b0;
        while (!(saw_long && saw_high) && cycles < 8192) begin
            @(negedge clk);
            cycles++;
            run      = aout[0] ? 0 : run + 1;
            saw_high = saw_high | aout[0];
            saw_long = saw_long | (run > 16);
        end
        assert (saw_long && saw_high) else begin
            failures++;
            $display("timeout: noise gating on channel a not seen within 8192 cycles");
        end
    endtask

    // ******************************
    // stimulus
    // ******************************
    initial begin
        logic [7:0] wval;
        logic [7:0] rval;
        logic [3:0] lvl [3];
        int         highs [3];
        int         period;
        int         seed;
        seed        = $urandom(32'haf84);
        clk         = 1'b0;
        rst_n       = 1'b0;
        a0          = 1'b0;
        wr_tick     = 1'b0;
        wdata       = 8'h00;
        rd_tick     = 1'b0;
        quiet_check = 1'b0;
        mismatches  = 0;
        failures    = 0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        quiet_for(2048);                        // reset state is silent

        // register readback over the whole map
        for (int a = 0; a < `AY_NUM_REGS; a++) begin
            wval = 8'($urandom);
            write_reg(4'(a), wval);
            read_reg(4'(a), rval);
            assert (rval == (wval & reg_mask(a))) else begin
                mismatches++;
                $display("MISMATCH at %0t: reg %0d read %h, expected %h",
                         $time, a, rval, wval & reg_mask(a));
            end
        end

        // zero amplitudes, any mixer
        write_reg(4'd8, 8'h00);
        write_reg(4'd9, 8'h00);
        write_reg(4'd10, 8'h00);
        write_reg(4'd7, 8'($urandom));
        repeat (2) @(posedge clk);
        quiet_for(2048);

        // fixed levels, both sources off so the gate stays high
        write_reg(4'd7, 8'h3F);
        for (int ch = 0; ch < 3; ch++) begin
            lvl[ch] = 4'($urandom);
            write_reg(4'(8 + ch), {4'h0, lvl[ch]});
        end
        repeat (4) @(posedge clk);
        for (int w = 0; w < 8; w++) begin
            for (int ch = 0; ch < 3; ch++)
                highs[ch] = 0;
            repeat (16) begin
                @(negedge clk);
                for (int ch = 0; ch < 3; ch++)
                    highs[ch] += aout[ch];
            end
            for (int ch = 0; ch < 3; ch++)
                assert (highs[ch] == lvl[ch]) else begin
                    mismatches++;
                    $display("MISMATCH at %0t: ch %0d had %0d highs in 16, expected %0d",
                             $time, ch, highs[ch], lvl[ch]);
                end
        end

        // tone on channel a only
        period = 1 + ($urandom % 20);
        write_reg(4'd8, 8'h0F);
        write_reg(4'd9, 8'h00);
        write_reg(4'd10, 8'h00);
        write_reg(4'd0, 8'(period));
        write_reg(4'd1, 8'h00);
        write_reg(4'd7, 8'h3E);                 // tone a on, all noise off
        measure_tone(period);

        // envelope, one-shot decay then repeating sawtooth
        period = 1 + ($urandom % 3);
        write_reg(4'd11, 8'(period));
        write_reg(4'd12, 8'h00);
        write_reg(4'd7, 8'h3F);
        write_reg(4'd8, 8'h10);
        write_reg(4'd9, 8'h10);
        write_reg(4'd10, 8'h10);
        write_reg(4'd13, 8'h00);
        wait_for_high(256, "envelope start");
        repeat (`AY_TONE_DIV * `AY_ENV_DIV * period + 512) @(posedge clk);
        quiet_for(512);                         // decayed and held at 0
        write_reg(4'd13, 8'h08);
        repeat (`AY_TONE_DIV * `AY_ENV_DIV * period + 512) @(posedge clk);
        wait_for_high(1024, "sawtooth repeat");

        // noise on channel a only
        write_reg(4'd8, 8'h0F);
        write_reg(4'd9, 8'h00);
        write_reg(4'd10, 8'h00);
        write_reg(4'd6, 8'h01);
        write_reg(4'd7, 8'h37);                 // noise a on, all tone off
        check_noise();

        $display("checks finished: %0d mismatches, %0d other failures",
                 mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
